// File: run.sh
#!/bin/sh
# Build the lane testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module lane_unit_tb -Mdir obj_dir

out=$(./obj_dir/Vlane_unit_tb 2>&1) || true
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -q "TEST PASSED"

// File: tb.f
verilog/lane_pkg.sv
verilog/register_bank.sv
verilog/index_unit.sv
verilog/operand_read.sv
verilog/exec_unit.sv
verilog/lane_unit.sv
testbench/lane_unit_sva.sv
testbench/lane_unit_tb.sv

// File: testbench/lane_unit_sva.sv
/* Commit timing assertions for the lane, bound into lane_unit */

`timescale 1ns/1ns

module lane_unit_sva (
	input logic clock,
	input logic reset,
	input logic en,
	input logic commit
);

	//////////////////////////////////////////////////////////////////////
	// Reset

	// Low in reset and in the first cycle out of it
	commit_low_in_reset: assert property (
		@(posedge clock) reset |=> !commit
	) else $error("commit high during reset or in the cycle after it");

	//////////////////////////////////////////////////////////////////////
	// Latency

	// Three edges from en to commit
	commit_after_en: assert property (
		@(posedge clock) disable iff (reset) $past(en, 3) |-> commit
	) else $error("en was not followed by commit three cycles later");

	no_stray_commit: assert property (
		@(posedge clock) disable iff (reset) commit |-> $past(en, 3)
	) else $error("commit without en three cycles earlier");

endmodule

bind lane_unit lane_unit_sva i_lane_unit_sva (
	.clock  (clock),
	.reset  (reset),
	.en     (en),
	.commit (commit)
);

// File: testbench/lane_unit_tb.sv
/* Lane testbench with clock, reset, directed and random stimulus,
   reference register model, result checks and watchdog */

`timescale 1ns/1ns

module lane_unit_tb;

	import lane_pkg::*;

	localparam int NUM_THREADS = 4;
	localparam int PHYS_REGS = NUM_THREADS * REGS_PER_THREAD;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_CMDS = 300;
	// Upper bound on issued commands including the directed ones
	localparam int MAX_CMDS = RANDOM_CMDS + 100;
	localparam int TIMEOUT_CYCLES = MAX_CMDS * 8 + 2 * RESET_CYCLES + 200;

	logic       clock;
	logic       reset;
	logic       en;
	lane_cmd_t  cmd;
	thread_id_t thread;
	logic       commit;
	wb_t        result;

	data_t  model [PHYS_REGS];
	wb_t    expected_q [$];
	wb_t    expected;
	integer seed;
	int     errors;
	int     checks;
	int     issued;

	lane_unit #(.NUM_THREADS(NUM_THREADS)) i_lane_unit (
		.clock  (clock),
		.reset  (reset),
		.en     (en),
		.cmd    (cmd),
		.thread (thread),
		.commit (commit),
		.result (result)
	);

	initial clock = 1'b0;

	always #4 clock = ~clock;

	// Window base of thread times 16 puts the thread in the upper bits
	function automatic phys_idx_t phys_index(thread_id_t t, reg_idx_t r);
		return {t, r};
	endfunction

	function automatic data_t compute_result(op_t op, data_t a, data_t b, data_t imm);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_movi: return imm;
			default: return '0;
		endcase
	endfunction

	function automatic void clear_model();
		for (int i = 0; i < PHYS_REGS; i++) begin
			model[i] = '0;
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic send_cmd(input op_t op, input reg_idx_t dst, input reg_idx_t s1,
			input reg_idx_t s2, input data_t imm, input thread_id_t t);
		lane_cmd_t c;
		wb_t       w;
		c.op = op;
		c.dst = dst;
		c.src1 = s1;
		c.src2 = s2;
		c.imm = imm;
		w.thread = t;
		w.dst = dst;
		w.data = compute_result(op, model[phys_index(t, s1)], model[phys_index(t, s2)], imm);
		@(posedge clock);
		en <= 1'b1;
		cmd <= c;
		thread <= t;
		expected_q.push_back(w);
		// Dependent commands come at least 3 cycles later
		model[phys_index(t, dst)] = w.data;
		issued++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			en <= 1'b0;
		end
	endtask

	task automatic pulse_reset();
		@(posedge clock);
		en <= 1'b0;
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		clear_model();
	endtask

	// Even and odd source registers of every thread read back as zero after reset
	task automatic cleared_banks();
		// Nonzero words first, so only the reset brings them back to zero
		for (int t = 0; t < NUM_THREADS; t++) begin
			send_cmd(op_movi, reg_idx_t'(2 * t), 4'd0, 4'd0,
				32'h3c00_0000 + data_t'(2 * t), thread_id_t'(t));
			send_cmd(op_movi, reg_idx_t'(2 * t + 1), 4'd0, 4'd0,
				32'h3c00_0000 + data_t'(2 * t + 1), thread_id_t'(t));
		end
		idle_cycles(4);
		pulse_reset();
		for (int t = 0; t < NUM_THREADS; t++) begin
			send_cmd(op_add, reg_idx_t'(15 - t), reg_idx_t'(2 * t), reg_idx_t'(2 * t + 1),
				'0, thread_id_t'(t));
		end
		idle_cycles(2);
	endtask

	task automatic alu_ops();
		send_cmd(op_movi, 4'd2, 4'd0, 4'd0, 32'h1234_5678, 2'd1);
		send_cmd(op_movi, 4'd3, 4'd0, 4'd0, 32'h0ff0_f00f, 2'd1);
		send_cmd(op_movi, 4'd4, 4'd0, 4'd0, 32'd5, 2'd1);
		send_cmd(op_movi, 4'd5, 4'd0, 4'd0, 32'd9, 2'd1);
		send_cmd(op_movi, 4'd11, 4'd0, 4'd0, 32'hffff_fff0, 2'd1);
		idle_cycles(2);
		send_cmd(op_add, 4'd6, 4'd2, 4'd3, '0, 2'd1);
		// 5 - 9 wraps below zero
		send_cmd(op_sub, 4'd7, 4'd4, 4'd5, '0, 2'd1);
		send_cmd(op_and, 4'd8, 4'd2, 4'd3, '0, 2'd1);
		send_cmd(op_or, 4'd9, 4'd2, 4'd3, '0, 2'd1);
		send_cmd(op_xor, 4'd10, 4'd2, 4'd3, '0, 2'd1);
		send_cmd(op_add, 4'd12, 4'd11, 4'd5, '0, 2'd1);
		send_cmd(op_sub, 4'd13, 4'd3, 4'd2, '0, 2'd1);
		idle_cycles(2);
	endtask

	// One value per thread in the same logical register
	task automatic thread_windows();
		for (int t = 0; t < NUM_THREADS; t++) begin
			send_cmd(op_movi, 4'd5, 4'd0, 4'd0, data_t'(32'h5a00_0000 + t), thread_id_t'(t));
		end
		idle_cycles(2);
		for (int t = 0; t < NUM_THREADS; t++) begin
			send_cmd(op_or, 4'd14, 4'd5, 4'd5, '0, thread_id_t'(t));
		end
		idle_cycles(2);
	endtask

	task automatic back_to_back();
		for (int i = 0; i < 8; i++) begin
			send_cmd(op_movi, reg_idx_t'(i), 4'd0, 4'd0, $random(seed), 2'd3);
		end
		for (int i = 0; i < 8; i++) begin
			send_cmd(op_xor, reg_idx_t'(i), reg_idx_t'(i + 8), reg_idx_t'(15 - i), '0, 2'd2);
		end
		idle_cycles(2);
	endtask

	task automatic random_stream();
		logic [31:0] r;
		logic [2:0]  sel;
		phys_idx_t   s1;
		phys_idx_t   s2;
		phys_idx_t   prev1;
		phys_idx_t   prev2;
		logic        prev1_v;
		logic        prev2_v;
		logic        clash;
		prev1 = '0;
		prev2 = '0;
		prev1_v = 1'b0;
		prev2_v = 1'b0;
		for (int n = 0; n < RANDOM_CMDS; n++) begin
			r = $random(seed);
			sel = r[16:14] % 3'd6;
			s1 = phys_index(r[1:0], r[9:6]);
			s2 = phys_index(r[1:0], r[13:10]);
			clash = (prev1_v && (s1 == prev1 || s2 == prev1)) ||
				(prev2_v && (s1 == prev2 || s2 == prev2));
			prev2 = prev1;
			prev2_v = prev1_v;
			// Slot becomes a bubble when a source was written too recently
			if (clash) begin
				idle_cycles(1);
				prev1_v = 1'b0;
			end else begin
				send_cmd(op_t'(sel), r[5:2], r[9:6], r[13:10], $random(seed), r[1:0]);
				prev1 = phys_index(r[1:0], r[5:2]);
				prev1_v = 1'b1;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result checks

	always @(negedge clock) begin
		if (!reset && commit) begin
			checks++;
			assert (expected_q.size() != 0) else begin
				errors++;
				$display("commit at %0t ns with no command outstanding", $time);
			end
			if (expected_q.size() != 0) begin
				expected = expected_q.pop_front();
				assert (result == expected) else begin
					errors++;
					$display("error at %0t ns: result = %h, expected %h", $time, result, expected);
				end
			end
		end
	end

	initial begin
		seed = 32'ha53bb803;
		errors = 0;
		checks = 0;
		issued = 0;
		reset = 1'b1;
		en = 1'b0;
		cmd = '0;
		thread = '0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		cleared_banks();
		alu_ops();
		thread_windows();
		back_to_back();
		random_stream();
		idle_cycles(6);
		assert (expected_q.size() == 0) else begin
			errors++;
			$display("%0d issued commands never committed", expected_q.size());
		end
		$display("commands %0d, commits checked %0d, errors %0d", issued, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * 8);
		$display("watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verilog/exec_unit.sv
/* Execute stage: integer ALU and result register driving
   write-back and commit */

`timescale 1ns/1ns

module exec_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  lane_pkg::opnd_stage_t   opnd_stage,
	output logic                    wb_valid,
	output lane_pkg::phys_idx_t     wb_index,
	output lane_pkg::wb_t           result
);

	import lane_pkg::*;

	data_t src1;
	data_t src2;
	data_t alu_out;

	assign src1 = opnd_stage.src1_data;
	assign src2 = opnd_stage.src2_data;

	//////////////////////////////////////////////////////////////////////
	// ALU

	always_comb begin
		case (opnd_stage.op)
			op_add:  alu_out = src1 + src2;
			op_sub:  alu_out = src1 - src2;
			op_and:  alu_out = src1 & src2;
			op_or:   alu_out = src1 | src2;
			op_xor:  alu_out = src1 ^ src2;
			// Immediate only, sources ignored
			op_movi: alu_out = opnd_stage.imm;
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Result register

	// Write enable to the banks and commit at the top
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= opnd_stage.valid;
		end
	end

	always_ff @(posedge clock) begin
		wb_index      <= opnd_stage.dst;
		result.thread <= opnd_stage.thread;
		result.dst    <= opnd_stage.ldst;
		result.data   <= alu_out;
	end

endmodule

// File: verilog/index_unit.sv
/* Index stage: command capture and mapping of logical registers
   into the thread's window of the register file */

`timescale 1ns/1ns

module index_unit #(
	parameter int NUM_THREADS = 4
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   en,
	input  lane_pkg::lane_cmd_t    cmd,
	input  lane_pkg::thread_id_t   thread,
	output lane_pkg::idx_stage_t   idx_stage
);

	import lane_pkg::*;

	localparam int PHYS_REGS = NUM_THREADS * REGS_PER_THREAD;
	localparam int PIDX_W = $clog2(PHYS_REGS);

	// Keeps the index inside the implemented register file
	localparam phys_idx_t IDX_MASK = phys_idx_t'((1 << PIDX_W) - 1);

	phys_idx_t src1_index;
	phys_idx_t src2_index;
	phys_idx_t dst_index;

	// Window base plus the logical number
	function automatic phys_idx_t window_index(thread_id_t t, reg_idx_t r);
		phys_idx_t base;
		base = phys_idx_t'(t) * phys_idx_t'(REGS_PER_THREAD);
		return (base + phys_idx_t'(r)) & IDX_MASK;
	endfunction

	always_comb begin
		src1_index = window_index(thread, cmd.src1);
		src2_index = window_index(thread, cmd.src2);
		dst_index  = window_index(thread, cmd.dst);
	end

	//////////////////////////////////////////////////////////////////////
	// Stage register

	always_ff @(posedge clock) begin
		if (reset) begin
			idx_stage.valid <= 1'b0;
		end else begin
			idx_stage.valid  <= en;
			idx_stage.op     <= cmd.op;
			idx_stage.imm    <= cmd.imm;
			idx_stage.src1   <= src1_index;
			idx_stage.src2   <= src2_index;
			idx_stage.dst    <= dst_index;
			// Kept for the commit report
			idx_stage.thread <= thread;
			idx_stage.ldst   <= cmd.dst;
		end
	end

endmodule

// File: verilog/lane_pkg.sv
/* Lane types: data and register widths, operation codes,
   command, write-back and pipeline stage structs */

package lane_pkg;

	typedef logic [31:0] data_t;

	// Logical register within one thread window
	typedef logic [3:0] reg_idx_t;

	typedef logic [1:0] thread_id_t;

	// Physical index sized for the largest thread count
	typedef logic [$bits(thread_id_t)+$bits(reg_idx_t)-1:0] phys_idx_t;

	localparam int REGS_PER_THREAD = 2 ** $bits(reg_idx_t);

	typedef enum logic [2:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_or   = 3'd3,
		op_xor  = 3'd4,
		op_movi = 3'd5
	} op_t;

	//////////////////////////////////////////////////////////////////////
	// Command and write-back

	typedef struct packed {
		op_t      op;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		data_t    imm;
	} lane_cmd_t;

	typedef struct packed {
		thread_id_t thread;
		reg_idx_t   dst;
		data_t      data;
	} wb_t;

	//////////////////////////////////////////////////////////////////////
	// Stage registers

	// Index stage, physical indices plus reporting fields
	typedef struct packed {
		logic       valid;
		op_t        op;
		data_t      imm;
		phys_idx_t  src1;
		phys_idx_t  src2;
		phys_idx_t  dst;
		thread_id_t thread;
		reg_idx_t   ldst;
	} idx_stage_t;

	// Operand stage, source words in place of source indices
	typedef struct packed {
		logic       valid;
		op_t        op;
		data_t      imm;
		data_t      src1_data;
		data_t      src2_data;
		phys_idx_t  dst;
		thread_id_t thread;
		reg_idx_t   ldst;
	} opnd_stage_t;

endpackage

// File: verilog/lane_unit.sv
/* SIMT lane top: index, operand and execute stages with
   write-back loop */

`timescale 1ns/1ns

module lane_unit #(
	parameter int NUM_THREADS = 4
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   en,
	input  lane_pkg::lane_cmd_t    cmd,
	input  lane_pkg::thread_id_t   thread,
	output logic                   commit,
	output lane_pkg::wb_t          result
);

	import lane_pkg::*;

	idx_stage_t  idx_stage;
	opnd_stage_t opnd_stage;
	phys_idx_t   wb_index;

	//////////////////////////////////////////////////////////////////////
	// Stages

	index_unit #(.NUM_THREADS(NUM_THREADS)) i_index_unit (
		.clock     (clock),
		.reset     (reset),
		.en        (en),
		.cmd       (cmd),
		.thread    (thread),
		.idx_stage (idx_stage)
	);

	// Write-back comes back from the execute stage
	operand_read #(.NUM_THREADS(NUM_THREADS)) i_operand_read (
		.clock      (clock),
		.reset      (reset),
		.idx_stage  (idx_stage),
		.wb_valid   (commit),
		.wb_index   (wb_index),
		.wb_data    (result.data),
		.opnd_stage (opnd_stage)
	);

	// Write enable doubles as the commit pulse
	exec_unit i_exec_unit (
		.clock      (clock),
		.reset      (reset),
		.opnd_stage (opnd_stage),
		.wb_valid   (commit),
		.wb_index   (wb_index),
		.result     (result)
	);

endmodule

// File: verilog/operand_read.sv
/* Operand stage: even/odd banked register file, source read
   steering and write-back steering */

`timescale 1ns/1ns

module operand_read #(
	parameter int NUM_THREADS = 4
) (
	input  logic                    clock,
	input  logic                    reset,
	input  lane_pkg::idx_stage_t    idx_stage,
	input  logic                    wb_valid,
	input  lane_pkg::phys_idx_t     wb_index,
	input  lane_pkg::data_t         wb_data,
	output lane_pkg::opnd_stage_t   opnd_stage
);

	import lane_pkg::*;

	localparam int PHYS_REGS = NUM_THREADS * REGS_PER_THREAD;
	localparam int BANK_DEPTH = PHYS_REGS / 2;
	localparam int BANK_AW = $clog2(BANK_DEPTH);

	typedef logic [BANK_AW-1:0] bank_addr_t;

	bank_addr_t src1_addr;
	bank_addr_t src2_addr;
	bank_addr_t wb_addr;
	logic       we_even;
	logic       we_odd;
	data_t      even_rdata1;
	data_t      even_rdata2;
	data_t      odd_rdata1;
	data_t      odd_rdata2;
	idx_stage_t stage_q;

	// Bit 0 picks the bank, the rest is the bank address
	assign src1_addr = idx_stage.src1[BANK_AW:1];
	assign src2_addr = idx_stage.src2[BANK_AW:1];
	assign wb_addr   = wb_index[BANK_AW:1];

	assign we_even = wb_valid & ~wb_index[0];
	assign we_odd  = wb_valid &  wb_index[0];

	//////////////////////////////////////////////////////////////////////
	// Banks

	register_bank #(.DEPTH(BANK_DEPTH)) bank_even (
		.clock  (clock),
		.reset  (reset),
		.we     (we_even),
		.waddr  (wb_addr),
		.wdata  (wb_data),
		.raddr1 (src1_addr),
		.raddr2 (src2_addr),
		.rdata1 (even_rdata1),
		.rdata2 (even_rdata2)
	);

	register_bank #(.DEPTH(BANK_DEPTH)) bank_odd (
		.clock  (clock),
		.reset  (reset),
		.we     (we_odd),
		.waddr  (wb_addr),
		.wdata  (wb_data),
		.raddr1 (src1_addr),
		.raddr2 (src2_addr),
		.rdata1 (odd_rdata1),
		.rdata2 (odd_rdata2)
	);

	// Command fields follow the bank read by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			stage_q.valid <= 1'b0;
		end else begin
			stage_q <= idx_stage;
		end
	end

	// Delayed bank bits select the read data
	always_comb begin
		opnd_stage.valid     = stage_q.valid;
		opnd_stage.op        = stage_q.op;
		opnd_stage.imm       = stage_q.imm;
		opnd_stage.src1_data = stage_q.src1[0] ? odd_rdata1 : even_rdata1;
		opnd_stage.src2_data = stage_q.src2[0] ? odd_rdata2 : even_rdata2;
		opnd_stage.dst       = stage_q.dst;
		opnd_stage.thread    = stage_q.thread;
		opnd_stage.ldst      = stage_q.ldst;
	end

endmodule

// File: verilog/register_bank.sv
/* One register file bank with two registered read ports
   and one write port */

`timescale 1ns/1ns

module register_bank #(
	parameter int DEPTH = 32
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       we,
	input  logic [$clog2(DEPTH)-1:0]   waddr,
	input  lane_pkg::data_t            wdata,
	input  logic [$clog2(DEPTH)-1:0]   raddr1,
	input  logic [$clog2(DEPTH)-1:0]   raddr2,
	output lane_pkg::data_t            rdata1,
	output lane_pkg::data_t            rdata2
);

	import lane_pkg::*;

	data_t mem [DEPTH];

	// Whole bank comes out of reset as zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Same-edge write is not seen, old word is returned
	always_ff @(posedge clock) begin
		rdata1 <= mem[raddr1];
		rdata2 <= mem[raddr2];
	end

endmodule
